// File: logic/pkt_sched_pkg.sv
// packet slot scheduling definitions
package pkt_sched_pkg;

  localparam int CORE_COUNT          = 4;
  localparam int SLOT_COUNT          = 8;
  localparam int CORE_ADDR_WIDTH     = 16;
  localparam int SLOT_LEAD_ZERO      = 8;
  localparam int SLOT_ADDR_EFF       = CORE_ADDR_WIDTH - 1 - SLOT_LEAD_ZERO;
  localparam int ADDR_WIDTH          = CORE_ADDR_WIDTH + $clog2(CORE_COUNT);
  localparam int LEN_WIDTH           = 16;
  localparam int TAG_WIDTH           = 8;
  localparam int MSG_WIDTH           = 64;
  localparam int CORE_FIFO_ADDR_SIZE = 2;
  localparam int PENDING_WIDTH       = 8;

  // core message field positions
  localparam int MSG_OP_LSB   = 60;
  localparam int MSG_SLOT_LSB = 48;
  localparam int MSG_LEN_LSB  = 0;

  typedef logic [$clog2(CORE_COUNT)-1:0] core_id_t;
  typedef logic [$clog2(SLOT_COUNT)-1:0] slot_id_t;
  typedef logic [SLOT_ADDR_EFF-1:0]      slot_addr_t;
  typedef logic [ADDR_WIDTH-1:0]         addr_t;
  typedef logic [LEN_WIDTH-1:0]          len_t;
  typedef logic [TAG_WIDTH-1:0]          tag_t;

  localparam slot_addr_t FIRST_SLOT_ADDR = 7'h40;
  localparam slot_addr_t SLOT_ADDR_STEP  = 7'h08;
  localparam addr_t      RX_WRITE_OFFSET = 'h08;

  typedef enum logic [3:0] {
    MSG_SLOT_DONE = 4'h1,
    MSG_SLOT_DROP = 4'h2
  } msg_opcode_e;

  typedef enum logic {
    DISP_IDLE,
    DISP_OFFER
  } dispatch_state_e;

  typedef enum logic [1:0] {
    REL_IDLE,
    REL_TX,
    REL_FREE
  } release_state_e;

  // core index on top, slot base below, low bits zero
  function automatic addr_t slot_base_addr(core_id_t core, slot_addr_t base);
    return {core, {(CORE_ADDR_WIDTH - SLOT_ADDR_EFF - SLOT_LEAD_ZERO){1'b0}},
            base, {SLOT_LEAD_ZERO{1'b0}}};
  endfunction

endpackage

// File: logic/pkt_sched_if.sv
// slot allocation and core message buses
`timescale 1ns/1ps

interface slot_alloc_if;
  logic                    avail;
  pkt_sched_pkg::core_id_t cand_core;
  pkt_sched_pkg::slot_id_t cand_slot;
  logic                    take;
  logic                    free_valid;
  pkt_sched_pkg::core_id_t free_core;
  pkt_sched_pkg::slot_id_t free_slot;

  modport tracker (
    output avail, cand_core, cand_slot,
    input  take, free_valid, free_core, free_slot
  );

  modport dispatch (
    input  avail, cand_core, cand_slot,
    output take
  );

  // returns finished slots to the tracker
  modport releaser (
    output free_valid, free_core, free_slot
  );
endinterface

interface core_msg_if;
  logic [pkt_sched_pkg::MSG_WIDTH-1:0] msg_data;
  pkt_sched_pkg::core_id_t             msg_core;
  logic                                msg_valid;
  logic                                msg_ready;

  modport arbiter (output msg_data, msg_core, msg_valid, input msg_ready);
  modport sink (input msg_data, msg_core, msg_valid, output msg_ready);
endinterface

// File: logic/slot_addr_table.sv
// slot base address table
`timescale 1ns/1ps

module slot_addr_table (
  input  logic                      logic_clk,
  input  logic                      rst_n,
  input  pkt_sched_pkg::slot_id_t   wr_no,
  input  pkt_sched_pkg::slot_addr_t wr_data,
  input  logic                      wr_valid,
  output pkt_sched_pkg::slot_addr_t slot_addr [pkt_sched_pkg::SLOT_COUNT]
);

  // one base per slot number, same for every core
  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      for (int n = 0; n < pkt_sched_pkg::SLOT_COUNT; n++) begin
        slot_addr[n] <= pkt_sched_pkg::slot_addr_t'(pkt_sched_pkg::FIRST_SLOT_ADDR +
                        n * pkt_sched_pkg::SLOT_ADDR_STEP);
      end
    end else if (wr_valid) begin
      slot_addr[wr_no] <= wr_data;
    end
  end

endmodule

// File: logic/slot_tracker.sv
// per-core free slot tracking
`timescale 1ns/1ps

module slot_tracker (
  input logic   logic_clk,
  input logic   rst_n,
  slot_alloc_if.tracker alloc
);

  logic [pkt_sched_pkg::SLOT_COUNT-1:0] free_map [pkt_sched_pkg::CORE_COUNT];
  pkt_sched_pkg::core_id_t last_core;
  pkt_sched_pkg::core_id_t cand_core;
  pkt_sched_pkg::slot_id_t cand_slot;
  logic                    any_free;

  // first core after the last one served that still has a free slot
  always_comb begin
    pkt_sched_pkg::core_id_t idx;
    idx       = last_core;
    cand_core = last_core;
    any_free  = 1'b0;
    for (int k = 1; k <= pkt_sched_pkg::CORE_COUNT; k++) begin
      idx = pkt_sched_pkg::core_id_t'(last_core + k);
      if (!any_free && |free_map[idx]) begin
        any_free  = 1'b1;
        cand_core = idx;
      end
    end
  end

  // lowest free slot inside the chosen core
  always_comb begin
    cand_slot = '0;
    for (int s = pkt_sched_pkg::SLOT_COUNT - 1; s >= 0; s--) begin
      if (free_map[cand_core][s]) begin
        cand_slot = pkt_sched_pkg::slot_id_t'(s);
      end
    end
  end

  assign alloc.avail     = any_free;
  assign alloc.cand_core = cand_core;
  assign alloc.cand_slot = cand_slot;

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      for (int c = 0; c < pkt_sched_pkg::CORE_COUNT; c++) begin
        free_map[c] <= '1;
      end
      last_core <= pkt_sched_pkg::core_id_t'(pkt_sched_pkg::CORE_COUNT - 1);
    end else begin
      // freeing an already free slot just rewrites a one
      if (alloc.free_valid) begin
        free_map[alloc.free_core][alloc.free_slot] <= 1'b1;
      end
      if (alloc.take) begin
        free_map[cand_core][cand_slot] <= 1'b0;
        last_core                      <= cand_core;
      end
    end
  end

endmodule

// File: logic/rx_dispatch.sv
// receive descriptor dispatch
`timescale 1ns/1ps

module rx_dispatch (
  input  logic                      logic_clk,
  input  logic                      rst_n,
  input  logic                      incoming_pkt_ready,
  input  pkt_sched_pkg::slot_addr_t slot_addr [pkt_sched_pkg::SLOT_COUNT],
  slot_alloc_if.dispatch            alloc,
  output pkt_sched_pkg::addr_t      rx_desc_addr,
  output pkt_sched_pkg::tag_t       rx_desc_tag,
  output logic                      rx_desc_valid,
  input  logic                      rx_desc_ready
);

  pkt_sched_pkg::dispatch_state_e    state;
  logic [pkt_sched_pkg::PENDING_WIDTH-1:0] pending;
  logic                              take;

  // claim a slot only when a packet is waiting and nothing is on offer
  assign take = (state == pkt_sched_pkg::DISP_IDLE) && (pending != '0) && alloc.avail;
  assign alloc.take    = take;
  assign rx_desc_valid = (state == pkt_sched_pkg::DISP_OFFER);

  // count of packets waiting for a slot stops at all ones
  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      case ({incoming_pkt_ready, take})
        2'b10: if (pending != '1) pending <= pending + 1'b1;
        2'b01: pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      state <= pkt_sched_pkg::DISP_IDLE;
    end else begin
      case (state)
        pkt_sched_pkg::DISP_IDLE:  if (take) state <= pkt_sched_pkg::DISP_OFFER;
        pkt_sched_pkg::DISP_OFFER: if (rx_desc_ready) state <= pkt_sched_pkg::DISP_IDLE;
        default: state <= pkt_sched_pkg::DISP_IDLE;
      endcase
    end
  end

  // descriptor fields hold through the offer
  always_ff @(posedge logic_clk) begin
    if (take) begin
      rx_desc_addr <= pkt_sched_pkg::slot_base_addr(alloc.cand_core,
                      slot_addr[alloc.cand_slot]) + pkt_sched_pkg::RX_WRITE_OFFSET;
      rx_desc_tag  <= pkt_sched_pkg::tag_t'({alloc.cand_core, alloc.cand_slot});
    end
  end

endmodule

// File: logic/core_msg_arbiter.sv
// core message FIFOs and round-robin merge
`timescale 1ns/1ps

module core_msg_arbiter (
  input logic logic_clk,
  input logic rst_n,
  input logic [pkt_sched_pkg::CORE_COUNT-1:0][pkt_sched_pkg::MSG_WIDTH-1:0] core_msg_data,
  input logic [pkt_sched_pkg::CORE_COUNT-1:0] core_msg_valid,
  core_msg_if.arbiter msg
);

  localparam int A     = pkt_sched_pkg::CORE_FIFO_ADDR_SIZE;
  localparam int DEPTH = 2 ** A;

  logic [pkt_sched_pkg::MSG_WIDTH-1:0] fifo_mem [pkt_sched_pkg::CORE_COUNT][DEPTH];
  logic [A:0]                          wr_ptr [pkt_sched_pkg::CORE_COUNT];
  logic [A:0]                          rd_ptr [pkt_sched_pkg::CORE_COUNT];
  logic [pkt_sched_pkg::CORE_COUNT-1:0] empty;
  logic [pkt_sched_pkg::CORE_COUNT-1:0] full;

  pkt_sched_pkg::core_id_t last_core;
  pkt_sched_pkg::core_id_t rr_core;
  pkt_sched_pkg::core_id_t grant;
  pkt_sched_pkg::core_id_t hold_core;
  logic                    rr_found;
  logic                    hold;
  logic                    accept;

  always_comb begin
    for (int c = 0; c < pkt_sched_pkg::CORE_COUNT; c++) begin
      empty[c] = (wr_ptr[c] == rd_ptr[c]);
      full[c]  = (wr_ptr[c][A] != rd_ptr[c][A]) && (wr_ptr[c][A-1:0] == rd_ptr[c][A-1:0]);
    end
  end

  // next non-empty FIFO after the last one granted
  always_comb begin
    pkt_sched_pkg::core_id_t idx;
    idx      = last_core;
    rr_core  = last_core;
    rr_found = 1'b0;
    for (int k = 1; k <= pkt_sched_pkg::CORE_COUNT; k++) begin
      idx = pkt_sched_pkg::core_id_t'(last_core + k);
      if (!rr_found && !empty[idx]) begin
        rr_found = 1'b1;
        rr_core  = idx;
      end
    end
  end

  // a stalled offer keeps its core so the data stays put
  assign grant  = hold ? hold_core : rr_core;
  assign accept = msg.msg_valid && msg.msg_ready;

  assign msg.msg_valid = hold || rr_found;
  assign msg.msg_core  = grant;
  assign msg.msg_data  = fifo_mem[grant][rd_ptr[grant][A-1:0]];

  // message written on the edge it is seen, dropped when full
  always_ff @(posedge logic_clk) begin
    for (int c = 0; c < pkt_sched_pkg::CORE_COUNT; c++) begin
      if (core_msg_valid[c] && !full[c]) begin
        fifo_mem[c][wr_ptr[c][A-1:0]] <= core_msg_data[c];
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      for (int c = 0; c < pkt_sched_pkg::CORE_COUNT; c++) begin
        wr_ptr[c] <= '0;
        rd_ptr[c] <= '0;
      end
      last_core <= pkt_sched_pkg::core_id_t'(pkt_sched_pkg::CORE_COUNT - 1);
      hold      <= 1'b0;
    end else begin
      for (int c = 0; c < pkt_sched_pkg::CORE_COUNT; c++) begin
        if (core_msg_valid[c] && !full[c]) wr_ptr[c] <= wr_ptr[c] + 1'b1;
      end
      if (accept) begin
        rd_ptr[grant] <= rd_ptr[grant] + 1'b1;
        last_core     <= grant;
      end
      hold <= msg.msg_valid && !msg.msg_ready;
    end
  end

  always_ff @(posedge logic_clk) begin
    hold_core <= grant;
  end

endmodule

// File: logic/tx_release.sv
// core message decode, transmit and slot release
`timescale 1ns/1ps

module tx_release (
  input  logic                      logic_clk,
  input  logic                      rst_n,
  input  pkt_sched_pkg::slot_addr_t slot_addr [pkt_sched_pkg::SLOT_COUNT],
  core_msg_if.sink                  msg,
  slot_alloc_if.releaser            alloc,
  output pkt_sched_pkg::addr_t      tx_desc_addr,
  output pkt_sched_pkg::len_t       tx_desc_len,
  output pkt_sched_pkg::tag_t       tx_desc_tag,
  output logic                      tx_desc_valid,
  input  logic                      tx_desc_ready
);

  pkt_sched_pkg::release_state_e state;
  pkt_sched_pkg::msg_opcode_e    opcode;
  pkt_sched_pkg::core_id_t       rel_core;
  pkt_sched_pkg::slot_id_t       msg_slot;
  pkt_sched_pkg::slot_id_t       rel_slot;
  logic                          accept;

  assign opcode   = pkt_sched_pkg::msg_opcode_e'(msg.msg_data[pkt_sched_pkg::MSG_OP_LSB +: 4]);
  assign msg_slot = msg.msg_data[pkt_sched_pkg::MSG_SLOT_LSB +: $bits(pkt_sched_pkg::slot_id_t)];

  // one message at a time, so a stalled descriptor backs up the FIFOs
  assign msg.msg_ready = (state == pkt_sched_pkg::REL_IDLE);
  assign accept        = msg.msg_valid && msg.msg_ready;

  assign tx_desc_valid    = (state == pkt_sched_pkg::REL_TX);
  assign alloc.free_valid = (state == pkt_sched_pkg::REL_FREE);
  assign alloc.free_core  = rel_core;
  assign alloc.free_slot  = rel_slot;

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      state <= pkt_sched_pkg::REL_IDLE;
    end else begin
      case (state)
        pkt_sched_pkg::REL_IDLE: begin
          if (accept) begin
            case (opcode)
              pkt_sched_pkg::MSG_SLOT_DONE: state <= pkt_sched_pkg::REL_TX;
              pkt_sched_pkg::MSG_SLOT_DROP: state <= pkt_sched_pkg::REL_FREE;
              // unknown opcodes are swallowed
              default: state <= pkt_sched_pkg::REL_IDLE;
            endcase
          end
        end
        pkt_sched_pkg::REL_TX:   if (tx_desc_ready) state <= pkt_sched_pkg::REL_FREE;
        pkt_sched_pkg::REL_FREE: state <= pkt_sched_pkg::REL_IDLE;
        default: state <= pkt_sched_pkg::REL_IDLE;
      endcase
    end
  end

  // slot and descriptor captured from the accepted message
  always_ff @(posedge logic_clk) begin
    if (accept) begin
      rel_core     <= msg.msg_core;
      rel_slot     <= msg_slot;
      tx_desc_addr <= pkt_sched_pkg::slot_base_addr(msg.msg_core, slot_addr[msg_slot]);
      tx_desc_len  <= msg.msg_data[pkt_sched_pkg::MSG_LEN_LSB +: pkt_sched_pkg::LEN_WIDTH];
      tx_desc_tag  <= pkt_sched_pkg::tag_t'({msg.msg_core, msg_slot});
    end
  end

endmodule

// File: logic/pkt_dispatch_top.sv
// packet slot scheduler top level
`timescale 1ns/1ps

module pkt_dispatch_top (
  input  logic                      logic_clk,
  input  logic                      rst_n,

  input  pkt_sched_pkg::slot_id_t   slot_addr_wr_no,
  input  pkt_sched_pkg::slot_addr_t slot_addr_wr_data,
  input  logic                      slot_addr_wr_valid,

  input  logic                      incoming_pkt_ready,

  output pkt_sched_pkg::addr_t      rx_desc_addr,
  output pkt_sched_pkg::tag_t       rx_desc_tag,
  output logic                      rx_desc_valid,
  input  logic                      rx_desc_ready,

  input  logic [pkt_sched_pkg::CORE_COUNT-1:0][pkt_sched_pkg::MSG_WIDTH-1:0] core_msg_data,
  input  logic [pkt_sched_pkg::CORE_COUNT-1:0] core_msg_valid,

  output pkt_sched_pkg::addr_t      tx_desc_addr,
  output pkt_sched_pkg::len_t       tx_desc_len,
  output pkt_sched_pkg::tag_t       tx_desc_tag,
  output logic                      tx_desc_valid,
  input  logic                      tx_desc_ready
);

  pkt_sched_pkg::slot_addr_t slot_addr [pkt_sched_pkg::SLOT_COUNT];

  slot_alloc_if alloc_bus ();
  core_msg_if   msg_bus ();

  slot_addr_table u_slot_addr_table (
    .logic_clk (logic_clk),
    .rst_n     (rst_n),
    .wr_no     (slot_addr_wr_no),
    .wr_data   (slot_addr_wr_data),
    .wr_valid  (slot_addr_wr_valid),
    .slot_addr (slot_addr)
  );

  slot_tracker u_slot_tracker (
    .logic_clk (logic_clk),
    .rst_n     (rst_n),
    .alloc     (alloc_bus.tracker)
  );

  rx_dispatch u_rx_dispatch (
    .logic_clk          (logic_clk),
    .rst_n              (rst_n),
    .incoming_pkt_ready (incoming_pkt_ready),
    .slot_addr          (slot_addr),
    .alloc              (alloc_bus.dispatch),
    .rx_desc_addr       (rx_desc_addr),
    .rx_desc_tag        (rx_desc_tag),
    .rx_desc_valid      (rx_desc_valid),
    .rx_desc_ready      (rx_desc_ready)
  );

  core_msg_arbiter u_core_msg_arbiter (
    .logic_clk      (logic_clk),
    .rst_n          (rst_n),
    .core_msg_data  (core_msg_data),
    .core_msg_valid (core_msg_valid),
    .msg            (msg_bus.arbiter)
  );

  tx_release u_tx_release (
    .logic_clk     (logic_clk),
    .rst_n         (rst_n),
    .slot_addr     (slot_addr),
    .msg           (msg_bus.sink),
    .alloc         (alloc_bus.releaser),
    .tx_desc_addr  (tx_desc_addr),
    .tx_desc_len   (tx_desc_len),
    .tx_desc_tag   (tx_desc_tag),
    .tx_desc_valid (tx_desc_valid),
    .tx_desc_ready (tx_desc_ready)
  );

endmodule

// File: bench/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic logic_clk,
  output logic rst_n
);

  // 40 ns period
  initial begin
    logic_clk = 1'b0;
    forever #20 logic_clk = ~logic_clk;
  end

  // reset held over three rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge logic_clk);
    @(negedge logic_clk);
    rst_n = 1'b1;
  end

endmodule

// File: bench/pkt_dispatch_tb.sv
// packet scheduler testbench
`timescale 1ns/1ps

module pkt_dispatch_tb;

  logic                      logic_clk;
  logic                      rst_n;
  pkt_sched_pkg::slot_id_t   slot_addr_wr_no;
  pkt_sched_pkg::slot_addr_t slot_addr_wr_data;
  logic                      slot_addr_wr_valid;
  logic                      incoming_pkt_ready;
  pkt_sched_pkg::addr_t      rx_desc_addr;
  pkt_sched_pkg::tag_t       rx_desc_tag;
  logic                      rx_desc_valid;
  logic                      rx_desc_ready;
  logic [3:0][63:0]          core_msg_data;
  logic [3:0]                core_msg_valid;
  pkt_sched_pkg::addr_t      tx_desc_addr;
  pkt_sched_pkg::len_t       tx_desc_len;
  pkt_sched_pkg::tag_t       tx_desc_tag;
  logic                      tx_desc_valid;
  logic                      tx_desc_ready;

  // reference model state
  integer                    seed;
  pkt_sched_pkg::slot_addr_t table_m [8];
  logic                      busy [4][8];
  logic                      tx_open [4][8];
  logic [15:0]               tx_len [4][8];
  logic                      in_flight [4];
  logic                      drop_open [4];
  int                        drop_slot [4];
  int                        pulses_sent;
  int                        rx_seen;
  int                        open_count;
  int                        drops_reused;
  int                        last_alloc;
  logic                      exact_mode;
  logic [7:0]                rx_log [$];

  // stalled offers seen on the previous edge
  logic                      rx_hold;
  logic                      tx_hold;
  pkt_sched_pkg::addr_t      rx_hold_addr;
  pkt_sched_pkg::addr_t      tx_hold_addr;
  pkt_sched_pkg::tag_t       rx_hold_tag;
  pkt_sched_pkg::tag_t       tx_hold_tag;
  pkt_sched_pkg::len_t       tx_hold_len;

  tb_clock_gen u_clock_gen (
    .logic_clk (logic_clk),
    .rst_n     (rst_n)
  );

  pkt_dispatch_top DUT (
    .logic_clk          (logic_clk),
    .rst_n              (rst_n),
    .slot_addr_wr_no    (slot_addr_wr_no),
    .slot_addr_wr_data  (slot_addr_wr_data),
    .slot_addr_wr_valid (slot_addr_wr_valid),
    .incoming_pkt_ready (incoming_pkt_ready),
    .rx_desc_addr       (rx_desc_addr),
    .rx_desc_tag        (rx_desc_tag),
    .rx_desc_valid      (rx_desc_valid),
    .rx_desc_ready      (rx_desc_ready),
    .core_msg_data      (core_msg_data),
    .core_msg_valid     (core_msg_valid),
    .tx_desc_addr       (tx_desc_addr),
    .tx_desc_len        (tx_desc_len),
    .tx_desc_tag        (tx_desc_tag),
    .tx_desc_valid      (tx_desc_valid),
    .tx_desc_ready      (tx_desc_ready)
  );

  task automatic end_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    end_with_failure();
  endtask

  // core index on top, table base shifted above the zero bits
  function automatic pkt_sched_pkg::addr_t expected_addr(input int c, input int s,
                                                         input int offset);
    pkt_sched_pkg::addr_t a;
    a = pkt_sched_pkg::addr_t'(c) << pkt_sched_pkg::CORE_ADDR_WIDTH;
    a = a | (pkt_sched_pkg::addr_t'(table_m[s]) << pkt_sched_pkg::SLOT_LEAD_ZERO);
    return a + pkt_sched_pkg::addr_t'(offset);
  endfunction

  // next core after the last served, lowest free slot in it
  function automatic logic [4:0] next_alloc();
    int         c;
    logic [4:0] pick;
    logic       found;
    pick  = '0;
    found = 1'b0;
    for (int k = 1; k <= 4; k++) begin
      c = (last_alloc + k) % 4;
      for (int s = 0; s < 8; s++) begin
        if (!found && !busy[c][s]) begin
          found = 1'b1;
          pick  = {2'(c), 3'(s)};
        end
      end
    end
    return pick;
  endfunction

  task automatic send_msg(input int c, input int s, input pkt_sched_pkg::msg_opcode_e op,
                          input logic [15:0] len);
    logic [63:0] m;
    m = {$random(seed), $random(seed)};
    m[63:60] = op;
    m[50:48] = 3'(s);
    m[15:0]  = len;
    core_msg_data[c]  = m;
    core_msg_valid[c] = 1'b1;
    in_flight[c]      = 1'b1;
    if (op == pkt_sched_pkg::MSG_SLOT_DONE) begin
      tx_open[c][s] = 1'b1;
      tx_len[c][s]  = len;
      open_count++;
    end else begin
      // core is blocked until the dropped slot shows up again
      busy[c][s]   = 1'b0;
      drop_open[c] = 1'b1;
      drop_slot[c] = s;
    end
  endtask

  task automatic pick_and_send(input int c);
    int   start;
    int   s;
    logic found;
    start = $random(seed) & 7;
    s     = 0;
    found = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (!found && busy[c][(start + i) % 8]) begin
        found = 1'b1;
        s     = (start + i) % 8;
      end
    end
    if (found) begin
      if (($random(seed) & 3) == 0) begin
        send_msg(c, s, pkt_sched_pkg::MSG_SLOT_DROP, 16'h0);
      end else begin
        send_msg(c, s, pkt_sched_pkg::MSG_SLOT_DONE, 16'($random(seed)));
      end
    end
  endtask

  // one falling edge of stimulus with readies stalled about a quarter of the time
  task automatic step(input logic pulse, input logic msgs);
    @(negedge logic_clk);
    incoming_pkt_ready = pulse;
    slot_addr_wr_valid = 1'b0;
    core_msg_valid     = '0;
    rx_desc_ready      = (($random(seed) & 3) != 0);
    tx_desc_ready      = (($random(seed) & 3) != 0);
    if (pulse) pulses_sent++;
    if (msgs) begin
      for (int c = 0; c < 4; c++) begin
        if (!in_flight[c] && ($random(seed) & 3) == 0) pick_and_send(c);
      end
    end
  endtask

  task automatic send_pulses(input int n);
    repeat (n) step(1'b1, 1'b0);
    step(1'b0, 1'b0);
  endtask

  task automatic write_table(input int no, input pkt_sched_pkg::slot_addr_t data);
    step(1'b0, 1'b0);
    slot_addr_wr_no    = 3'(no);
    slot_addr_wr_data  = data;
    slot_addr_wr_valid = 1'b1;
    table_m[no]        = data;
  endtask

  task automatic wait_rx(input int target, input string what);
    int t;
    t = 0;
    while (rx_seen < target) begin
      step(1'b0, 1'b0);
      t++;
      if (t > 500) report_timeout(what);
    end
  endtask

  // descriptor monitor
  always @(posedge logic_clk) begin
    int c;
    int s;
    if (rst_n) begin
      if (rx_hold) begin
        check_value("rx_desc_valid", rx_desc_valid, 1);
        check_value("rx_desc_addr", rx_desc_addr, rx_hold_addr);
        check_value("rx_desc_tag", rx_desc_tag, rx_hold_tag);
      end
      if (tx_hold) begin
        check_value("tx_desc_valid", tx_desc_valid, 1);
        check_value("tx_desc_addr", tx_desc_addr, tx_hold_addr);
        check_value("tx_desc_len", tx_desc_len, tx_hold_len);
        check_value("tx_desc_tag", tx_desc_tag, tx_hold_tag);
      end
      if (rx_desc_valid && rx_desc_ready) begin
        c = rx_desc_tag[4:3];
        s = rx_desc_tag[2:0];
        check_value("rx_desc_tag upper bits", rx_desc_tag[7:5], 0);
        if (exact_mode) check_value("rx_desc_tag", rx_desc_tag, {3'b000, next_alloc()});
        check_value("rx_desc_tag slot busy", busy[c][s], 0);
        check_value("rx_desc_addr", rx_desc_addr,
                    expected_addr(c, s, pkt_sched_pkg::RX_WRITE_OFFSET));
        busy[c][s] = 1'b1;
        last_alloc = c;
        rx_seen++;
        rx_log.push_back(rx_desc_tag);
        if (drop_open[c] && drop_slot[c] == s) begin
          drop_open[c] = 1'b0;
          in_flight[c] = 1'b0;
          drops_reused++;
        end
      end
      if (tx_desc_valid && tx_desc_ready) begin
        c = tx_desc_tag[4:3];
        s = tx_desc_tag[2:0];
        check_value("tx_desc_tag upper bits", tx_desc_tag[7:5], 0);
        check_value("tx_desc_tag outstanding", tx_open[c][s], 1);
        check_value("tx_desc_len", tx_desc_len, tx_len[c][s]);
        check_value("tx_desc_addr", tx_desc_addr, expected_addr(c, s, 0));
        tx_open[c][s] = 1'b0;
        busy[c][s]    = 1'b0;
        in_flight[c]  = 1'b0;
        open_count--;
      end
      rx_hold      = rx_desc_valid && !rx_desc_ready;
      rx_hold_addr = rx_desc_addr;
      rx_hold_tag  = rx_desc_tag;
      tx_hold      = tx_desc_valid && !tx_desc_ready;
      tx_hold_addr = tx_desc_addr;
      tx_hold_len  = tx_desc_len;
      tx_hold_tag  = tx_desc_tag;
    end
  end

  initial begin
    int t;
    int c;
    int s;
    seed               = 67;
    slot_addr_wr_no    = '0;
    slot_addr_wr_data  = '0;
    slot_addr_wr_valid = 1'b0;
    incoming_pkt_ready = 1'b0;
    rx_desc_ready      = 1'b0;
    core_msg_data      = '0;
    core_msg_valid     = '0;
    tx_desc_ready      = 1'b0;
    pulses_sent        = 0;
    rx_seen            = 0;
    open_count         = 0;
    drops_reused       = 0;
    last_alloc         = 3;
    exact_mode         = 1'b1;
    rx_hold            = 1'b0;
    tx_hold            = 1'b0;
    for (int n = 0; n < 8; n++) begin
      table_m[n] = pkt_sched_pkg::slot_addr_t'(pkt_sched_pkg::FIRST_SLOT_ADDR +
                   n * pkt_sched_pkg::SLOT_ADDR_STEP);
    end
    for (int k = 0; k < 4; k++) begin
      in_flight[k] = 1'b0;
      drop_open[k] = 1'b0;
      drop_slot[k] = 0;
      for (int n = 0; n < 8; n++) begin
        busy[k][n]    = 1'b0;
        tx_open[k][n] = 1'b0;
        tx_len[k][n]  = '0;
      end
    end

    t = 0;
    while (rst_n !== 1'b1) begin
      @(negedge logic_clk);
      t++;
      if (t > 10) report_timeout("reset release");
    end

    // default table, cores in turn, slot 0 then slot 1
    send_pulses(8);
    wait_rx(8, "first eight receive descriptors");
    for (int i = 0; i < 8; i++) begin
      check_value("rx_desc_tag order", rx_log[i], {3'b000, 2'(i % 4), 3'(i / 4)});
    end

    // new table contents, then fill every remaining slot
    repeat (8) write_table($random(seed) & 7, 7'($random(seed)));
    send_pulses(24);
    wait_rx(32, "receive descriptors up to a full slot map");

    // no slot left, so the packet waits for a drop
    send_pulses(1);
    repeat (20) begin
      step(1'b0, 1'b0);
      check_value("rx_desc_valid", rx_desc_valid, 0);
    end
    c = $random(seed) & 3;
    s = $random(seed) & 7;
    step(1'b0, 1'b0);
    send_msg(c, s, pkt_sched_pkg::MSG_SLOT_DROP, 16'h0);
    wait_rx(33, "receive descriptor for the dropped slot");
    check_value("rx_desc_tag after drop", rx_log[32], {3'b000, 2'(c), 3'(s)});

    // random load with done and drop traffic
    exact_mode = 1'b0;
    repeat (800) step(($random(seed) & 3) == 0, 1'b1);

    t = 0;
    while (rx_seen < pulses_sent || open_count != 0) begin
      step(1'b0, rx_seen < pulses_sent);
      t++;
      if (t > 4000) report_timeout("outstanding descriptors to drain");
    end
    repeat (20) step(1'b0, 1'b0);
    check_value("rx descriptor count", rx_seen, pulses_sent);
    check_value("dropped slots reused", drops_reused > 1, 1);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: compile.f
logic/pkt_sched_pkg.sv
logic/pkt_sched_if.sv
logic/slot_addr_table.sv
logic/slot_tracker.sv
logic/rx_dispatch.sv
logic/core_msg_arbiter.sv
logic/tx_release.sv
logic/pkt_dispatch_top.sv
bench/tb_clock_gen.sv
bench/pkt_dispatch_tb.sv

// File: Makefile
TOP := pkt_dispatch_tb

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
